//--- Bender.yml
package:
  name: camtracker

sources:
  # Design, package first
  - files:
      - hw/camTrackPkg.sv
      - hw/ccdCapture.sv
      - hw/bayerToRgb.sv
      - hw/lightTracker.sv
      - hw/crosshairOverlay.sv
      - hw/apbRegs.sv
      - hw/camTracker.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tests/camTracker_assert.sv
      - tests/camTrackerTb.sv

//--- compile.f
hw/camTrackPkg.sv
hw/ccdCapture.sv
hw/bayerToRgb.sv
hw/lightTracker.sv
hw/crosshairOverlay.sv
hw/apbRegs.sv
hw/camTracker.sv
tests/camTracker_assert.sv
tests/camTrackerTb.sv

//--- hw/apbRegs.sv
`timescale 1ns/1ns
`default_nettype none

module apbRegs
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input camTrackPkg::apbReq_t apbReq,
	output camTrackPkg::apbRsp_t apbRsp,
	output camTrackPkg::ctrlReg_t ctrl,
	input camTrackPkg::trackResult_t spot,
	input logic [camTrackPkg::frameCountBits-1:0] frameCount
);

	logic access;
	logic mapped;
	logic readOnly;
	logic [31:0] readData;

	// Access phase, no wait states
	assign access = apbReq.psel & apbReq.penable;

	// ========================================
	// Address decode and read mux
	// ========================================
	always_comb
	begin
		mapped = 1'b1;
		readOnly = 1'b0;
		readData = '0;
		case (apbReq.paddr)
			camTrackPkg::regCtrlAddr:
				readData = {30'b0, ctrl.overlayEnable, ctrl.captureEnable};
			camTrackPkg::regThreshAddr:
				readData = 32'(ctrl.threshold);
			camTrackPkg::regStatusAddr:
			begin
				readOnly = 1'b1;
				readData = {spot.found, 5'b0, spot.centreY, 6'b0, spot.centreX};
			end
			camTrackPkg::regFrameAddr:
			begin
				readOnly = 1'b1;
				readData = 32'(frameCount);
			end
			default:
				mapped = 1'b0;
		endcase
	end

	always_comb
	begin
		apbRsp.pready = access;
		apbRsp.pslverr = access & (~mapped | (apbReq.pwrite & readOnly));
		apbRsp.prdata = (access & ~apbReq.pwrite) ? readData : '0;
	end

	// Control and threshold registers
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			ctrl <= '0;
		else if (access && apbReq.pwrite)
		begin
			if (apbReq.paddr == camTrackPkg::regCtrlAddr)
			begin
				ctrl.captureEnable <= apbReq.pwdata[0];
				ctrl.overlayEnable <= apbReq.pwdata[1];
			end
			if (apbReq.paddr == camTrackPkg::regThreshAddr)
				ctrl.threshold <= apbReq.pwdata[camTrackPkg::pixelBits-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/bayerToRgb.sv
`timescale 1ns/1ns
`default_nettype none

module bayerToRgb
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input camTrackPkg::rawPixel_t rawIn,
	output camTrackPkg::rgbPixel_t rgbOut
);

	// One even line of samples, G R G R ...
	logic [camTrackPkg::pixelBits-1:0] lineBuf [camTrackPkg::maxLineWidth];

	logic [camTrackPkg::pixelBits-1:0] prevData;
	logic oddSite;
	logic s1Fire;
	logic [camTrackPkg::pixelBits-1:0] s1GEven;
	logic [camTrackPkg::pixelBits-1:0] s1R;
	logic [camTrackPkg::pixelBits-1:0] s1B;
	logic [camTrackPkg::pixelBits-1:0] s1GOdd;
	logic [camTrackPkg::coordBits-1:0] s1X;
	logic [camTrackPkg::coordBits-1:0] s1Y;
	logic [camTrackPkg::pixelBits:0] greenSum;

	// Bottom right corner of each 2x2 block
	assign oddSite = rawIn.valid & rawIn.x[0] & rawIn.y[0];

	// ========================================
	// Stage 1, line buffer access
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rawIn.valid)
		begin
			prevData <= rawIn.data;
			if (!rawIn.y[0])
				lineBuf[rawIn.x] <= rawIn.data;
		end

		// Even line pair sits at x-1 and x
		s1GEven <= lineBuf[{rawIn.x[camTrackPkg::coordBits-1:1], 1'b0}];
		s1R <= lineBuf[rawIn.x];

		// Odd line B G, B is the held pixel
		s1B <= prevData;
		s1GOdd <= rawIn.data;
		s1X <= rawIn.x;
		s1Y <= rawIn.y;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			s1Fire <= 1'b0;
		else
			s1Fire <= oddSite;
	end

	// ========================================
	// Stage 2, colour output
	// ========================================
	assign greenSum = {1'b0, s1GEven} + {1'b0, s1GOdd};

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			rgbOut <= '0;
		end
		else
		begin
			rgbOut.valid <= s1Fire;
			rgbOut.red <= s1R;
			rgbOut.green <= greenSum[camTrackPkg::pixelBits:1];
			rgbOut.blue <= s1B;
			rgbOut.x <= s1X >> 1;
			rgbOut.y <= s1Y >> 1;
		end
	end

endmodule

`default_nettype wire

//--- hw/camTrackPkg.sv
`default_nettype none

package camTrackPkg;

	// ========================================
	// Sizes
	// ========================================
	localparam int pixelBits = 12;
	localparam int coordBits = 10;
	localparam int maxLineWidth = 640;
	localparam int frameCountBits = 16;

	// APB byte addresses
	localparam logic [3:0] regCtrlAddr = 4'h0;
	localparam logic [3:0] regThreshAddr = 4'h4;
	localparam logic [3:0] regStatusAddr = 4'h8;
	localparam logic [3:0] regFrameAddr = 4'hC;

	// Crosshair colour, pure red
	localparam logic [pixelBits-1:0] markerRed = '1;
	localparam logic [pixelBits-1:0] markerGreen = '0;
	localparam logic [pixelBits-1:0] markerBlue = '0;

	// ========================================
	// Stream and register types
	// ========================================

	// Raw Bayer sample from the sensor
	typedef struct packed {
		logic valid;
		logic [pixelBits-1:0] data;
		logic [coordBits-1:0] x;
		logic [coordBits-1:0] y;
		logic frameEnd;
	} rawPixel_t;

	// Half resolution colour pixel, coordinates in 2x2 blocks
	typedef struct packed {
		logic valid;
		logic [pixelBits-1:0] red;
		logic [pixelBits-1:0] green;
		logic [pixelBits-1:0] blue;
		logic [coordBits-1:0] x;
		logic [coordBits-1:0] y;
	} rgbPixel_t;

	// Spot centre in raw pixel units
	typedef struct packed {
		logic found;
		logic [coordBits-1:0] centreX;
		logic [coordBits-1:0] centreY;
	} trackResult_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	typedef struct packed {
		logic captureEnable;
		logic overlayEnable;
		logic [pixelBits-1:0] threshold;
	} ctrlReg_t;

endpackage

`default_nettype wire

//--- hw/camTracker.sv
`timescale 1ns/1ns
`default_nettype none

module camTracker
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input logic [camTrackPkg::pixelBits-1:0] d5mData,
	input logic d5mFval,
	input logic d5mLval,
	input camTrackPkg::apbReq_t apbReq,
	output camTrackPkg::apbRsp_t apbRsp,
	output camTrackPkg::rgbPixel_t pixelOut
);

	camTrackPkg::rawPixel_t rawPixel;
	camTrackPkg::rgbPixel_t rgbPixel;
	camTrackPkg::trackResult_t spot;
	camTrackPkg::ctrlReg_t ctrl;
	logic [camTrackPkg::frameCountBits-1:0] frameCount;

	// ========================================
	// Sensor front end
	// ========================================
	ccdCapture capture0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.d5mData(d5mData),
		.d5mFval(d5mFval),
		.d5mLval(d5mLval),
		.captureEnable(ctrl.captureEnable),
		.rawOut(rawPixel),
		.frameCount(frameCount)
	);

	// Both consumers see the same raw stream
	bayerToRgb demosaic0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.rawIn(rawPixel),
		.rgbOut(rgbPixel)
	);

	lightTracker tracker0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.rawIn(rawPixel),
		.threshold(ctrl.threshold),
		.result(spot)
	);

	crosshairOverlay overlay0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.rgbIn(rgbPixel),
		.spot(spot),
		.overlayEnable(ctrl.overlayEnable),
		.pixelOut(pixelOut)
	);

	// Register block
	apbRegs regs0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.ctrl(ctrl),
		.spot(spot),
		.frameCount(frameCount)
	);

endmodule

`default_nettype wire

//--- hw/ccdCapture.sv
`timescale 1ns/1ns
`default_nettype none

module ccdCapture
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input logic [camTrackPkg::pixelBits-1:0] d5mData,
	input logic d5mFval,
	input logic d5mLval,
	input logic captureEnable,
	output camTrackPkg::rawPixel_t rawOut,
	output logic [camTrackPkg::frameCountBits-1:0] frameCount
);

	logic [camTrackPkg::pixelBits-1:0] rData;
	logic rFval;
	logic rLval;
	logic prevFval;
	logic prevLval;
	logic frameActive;
	logic [camTrackPkg::coordBits-1:0] xCount;
	logic [camTrackPkg::coordBits-1:0] yCount;
	logic [camTrackPkg::coordBits-1:0] curX;
	logic [camTrackPkg::coordBits-1:0] curY;
	logic fvalRise;
	logic fvalFall;
	logic lineEnd;
	logic pixelValid;

	// ========================================
	// Pin registers and edge detection
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		rData <= d5mData;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			rFval <= 1'b0;
			rLval <= 1'b0;
			prevFval <= 1'b0;
			prevLval <= 1'b0;
		end
		else
		begin
			rFval <= d5mFval;
			rLval <= d5mLval;
			prevFval <= rFval;
			prevLval <= rLval;
		end
	end

	assign fvalRise = rFval & ~prevFval;
	assign fvalFall = prevFval & ~rFval;
	assign lineEnd = prevLval & ~rLval;

	// Enable only sampled at the start of a frame
	assign pixelValid = rFval & rLval & (fvalRise ? captureEnable : frameActive);
	assign curX = fvalRise ? '0 : xCount;
	assign curY = fvalRise ? '0 : yCount;

	// ========================================
	// Counters and output stage
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			frameActive <= 1'b0;
			xCount <= '0;
			yCount <= '0;
			frameCount <= '0;
			rawOut <= '0;
		end
		else
		begin
			rawOut.valid <= pixelValid;
			rawOut.data <= rData;
			rawOut.x <= curX;
			rawOut.y <= curY;
			rawOut.frameEnd <= fvalFall & frameActive;

			if (fvalRise)
				frameActive <= captureEnable;
			else if (fvalFall)
				frameActive <= 1'b0;

			if (fvalFall && frameActive)
				frameCount <= frameCount + 1'b1;

			if (pixelValid)
			begin
				xCount <= curX + 1'b1;
				yCount <= curY;
			end
			else if (fvalRise)
			begin
				xCount <= '0;
				yCount <= '0;
			end
			else if (lineEnd)
			begin
				xCount <= '0;
				// Only lines that carried pixels advance y
				if (xCount != '0)
					yCount <= yCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/crosshairOverlay.sv
`timescale 1ns/1ns
`default_nettype none

module crosshairOverlay
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input camTrackPkg::rgbPixel_t rgbIn,
	input camTrackPkg::trackResult_t spot,
	input logic overlayEnable,
	output camTrackPkg::rgbPixel_t pixelOut
);

	logic [camTrackPkg::coordBits-1:0] crossX;
	logic [camTrackPkg::coordBits-1:0] crossY;
	logic onCross;

	// Spot centre is in raw units, the stream in 2x2 blocks
	assign crossX = spot.centreX >> 1;
	assign crossY = spot.centreY >> 1;

	assign onCross = overlayEnable & spot.found & rgbIn.valid &
		((rgbIn.x == crossX) | (rgbIn.y == crossY));

	// ========================================
	// Output register
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			pixelOut <= '0;
		end
		else
		begin
			pixelOut <= rgbIn;
			if (onCross)
			begin
				pixelOut.red <= camTrackPkg::markerRed;
				pixelOut.green <= camTrackPkg::markerGreen;
				pixelOut.blue <= camTrackPkg::markerBlue;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/lightTracker.sv
`timescale 1ns/1ns
`default_nettype none

module lightTracker
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input camTrackPkg::rawPixel_t rawIn,
	input logic [camTrackPkg::pixelBits-1:0] threshold,
	output camTrackPkg::trackResult_t result
);

	logic [camTrackPkg::coordBits-1:0] minX;
	logic [camTrackPkg::coordBits-1:0] maxX;
	logic [camTrackPkg::coordBits-1:0] minY;
	logic [camTrackPkg::coordBits-1:0] maxY;
	logic anyHit;
	logic bright;
	logic [camTrackPkg::coordBits:0] sumX;
	logic [camTrackPkg::coordBits:0] sumY;

	assign bright = rawIn.valid && (rawIn.data >= threshold);

	// Midpoints, one extra bit for the carry
	assign sumX = {1'b0, minX} + {1'b0, maxX};
	assign sumY = {1'b0, minY} + {1'b0, maxY};

	// ========================================
	// Bounding box of bright pixels
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			minX <= '1;
			maxX <= '0;
			minY <= '1;
			maxY <= '0;
			anyHit <= 1'b0;
		end
		else if (rawIn.frameEnd)
		begin
			// Empty box for the next frame
			minX <= '1;
			maxX <= '0;
			minY <= '1;
			maxY <= '0;
			anyHit <= 1'b0;
		end
		else if (bright)
		begin
			anyHit <= 1'b1;
			if (rawIn.x < minX)
				minX <= rawIn.x;
			if (rawIn.x > maxX)
				maxX <= rawIn.x;
			if (rawIn.y < minY)
				minY <= rawIn.y;
			if (rawIn.y > maxY)
				maxY <= rawIn.y;
		end
	end

	// ========================================
	// Per frame result
	// ========================================
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			result <= '0;
		end
		else if (rawIn.frameEnd)
		begin
			if (anyHit)
			begin
				result.found <= 1'b1;
				result.centreX <= sumX[camTrackPkg::coordBits:1];
				result.centreY <= sumY[camTrackPkg::coordBits:1];
			end
			else
			begin
				// Nothing above threshold this frame
				result <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/camTrackerTb.sv
`timescale 1ns/1ns
`default_nettype none

module camTrackerTb;

	typedef logic [camTrackPkg::pixelBits-1:0] sample_t;
	typedef logic [camTrackPkg::coordBits-1:0] coord_t;

	localparam int clkPeriod = 200;
	localparam int resetCycles = 8;
	localparam int maxWidth = 16;
	localparam int maxHeight = 8;
	localparam int numFrames = 11;
	// Longest line blanking on every line, plus start, tail and vertical gap
	localparam int frameCycles = maxHeight * (4 + maxWidth) + 16;
	localparam int timeoutCycles = 2 * (numFrames * frameCycles + 200 + resetCycles);
	localparam sample_t brightLevel = 12'hF00;

	logic D5M_PIXLCLK;
	logic rst;
	sample_t d5mData;
	logic d5mFval;
	logic d5mLval;
	camTrackPkg::apbReq_t apbReq;
	camTrackPkg::apbRsp_t apbRsp;
	camTrackPkg::rgbPixel_t pixelOut;

	logic [15:0] lfsrState;
	int valueErrors;
	int otherErrors;
	int capturedFrames;
	int frameWidth;
	int frameHeight;
	sample_t frame [maxHeight][maxWidth];
	camTrackPkg::rgbPixel_t expected [$];
	camTrackPkg::rgbPixel_t expPixel;
	camTrackPkg::trackResult_t modelSpot;
	logic modelOverlay;

	camTracker dut0 (
		.D5M_PIXLCLK(D5M_PIXLCLK),
		.rst(rst),
		.d5mData(d5mData),
		.d5mFval(d5mFval),
		.d5mLval(d5mLval),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.pixelOut(pixelOut)
	);

	initial
	begin
		D5M_PIXLCLK = 1'b0;
		forever
			#(clkPeriod / 2) D5M_PIXLCLK = ~D5M_PIXLCLK;
	end

	// ========================================
	// Random source, 16 bit Fibonacci LFSR
	// ========================================
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	// ========================================
	// APB access
	// ========================================
	task automatic apbAccess(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge D5M_PIXLCLK);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = write;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(negedge D5M_PIXLCLK);
		apbReq.penable = 1'b1;
		// Mid low phase, response settled
		#(clkPeriod / 4);
		assert (apbRsp.pready)
		else
		begin
			otherErrors++;
			$display("APB access to address %h did not complete in its access phase", addr);
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		@(negedge D5M_PIXLCLK);
		apbReq = '0;
	endtask

	task automatic regWrite(input logic [3:0] addr, input logic [31:0] data,
		input logic expectErr);
		logic [31:0] rdata;
		logic err;
		apbAccess(1'b1, addr, data, rdata, err);
		assert (err == expectErr)
		else
		begin
			valueErrors++;
			$display("Error: pslverr on write to %h expected %h got %h", addr, expectErr, err);
		end
	endtask

	task automatic regCheck(input logic [3:0] addr, input logic [31:0] exp,
		input logic expectErr, input string name);
		logic [31:0] rdata;
		logic err;
		apbAccess(1'b0, addr, '0, rdata, err);
		assert (err == expectErr)
		else
		begin
			valueErrors++;
			$display("Error: pslverr on %s read expected %h got %h", name, expectErr, err);
		end
		if (!expectErr)
		begin
			assert (rdata == exp)
			else
			begin
				valueErrors++;
				$display("Error: prdata of %s expected %h got %h", name, exp, rdata);
			end
		end
	endtask

	// ========================================
	// Frame generation and reference model
	// ========================================
	task automatic makeFrame(input logic withBright);
		int bx;
		int by;
		frameWidth = 2 + int'(randBits(4) % 15);
		frameHeight = 2 + int'(randBits(3) % 7);
		for (int y = 0; y < frameHeight; y++)
		begin
			for (int x = 0; x < frameWidth; x++)
			begin
				if (withBright && randBits(4) == 0)
					frame[y][x] = brightLevel | sample_t'(randBits(8));
				else
					frame[y][x] = sample_t'(randBits(11));
			end
		end
		// At least one spot pixel
		if (withBright)
		begin
			bx = int'(randBits(4)) % frameWidth;
			by = int'(randBits(3)) % frameHeight;
			frame[by][bx] = brightLevel | sample_t'(randBits(8));
		end
	endtask

	// G R over B G, one output per 2x2 block
	task automatic predictPixels();
		camTrackPkg::rgbPixel_t p;
		logic [camTrackPkg::pixelBits:0] gSum;
		for (int y = 1; y < frameHeight; y += 2)
		begin
			for (int x = 1; x < frameWidth; x += 2)
			begin
				gSum = frame[y-1][x-1] + frame[y][x];
				p.valid = 1'b1;
				p.red = frame[y-1][x];
				p.green = gSum[camTrackPkg::pixelBits:1];
				p.blue = frame[y][x-1];
				p.x = coord_t'(x / 2);
				p.y = coord_t'(y / 2);
				if (modelOverlay && modelSpot.found &&
					(p.x == modelSpot.centreX / 2 || p.y == modelSpot.centreY / 2))
				begin
					p.red = 12'hFFF;
					p.green = 12'h000;
					p.blue = 12'h000;
				end
				expected.push_back(p);
			end
		end
	endtask

	task automatic predictSpot();
		int minX;
		int maxX;
		int minY;
		int maxY;
		logic hit;
		minX = maxWidth;
		maxX = 0;
		minY = maxHeight;
		maxY = 0;
		hit = 1'b0;
		for (int y = 0; y < frameHeight; y++)
		begin
			for (int x = 0; x < frameWidth; x++)
			begin
				if (frame[y][x] >= brightLevel)
				begin
					hit = 1'b1;
					minX = (x < minX) ? x : minX;
					maxX = (x > maxX) ? x : maxX;
					minY = (y < minY) ? y : minY;
					maxY = (y > maxY) ? y : maxY;
				end
			end
		end
		modelSpot = '0;
		if (hit)
		begin
			modelSpot.found = 1'b1;
			modelSpot.centreX = coord_t'((minX + maxX) / 2);
			modelSpot.centreY = coord_t'((minY + maxY) / 2);
		end
	endtask

	task automatic driveFrame();
		int gap;
		@(negedge D5M_PIXLCLK);
		d5mFval = 1'b1;
		for (int y = 0; y < frameHeight; y++)
		begin
			gap = 1 + int'(randBits(2));
			repeat (gap)
			begin
				@(negedge D5M_PIXLCLK);
				d5mLval = 1'b0;
				d5mData = sample_t'(randBits(12));
			end
			for (int x = 0; x < frameWidth; x++)
			begin
				@(negedge D5M_PIXLCLK);
				d5mLval = 1'b1;
				d5mData = frame[y][x];
			end
		end
		@(negedge D5M_PIXLCLK);
		d5mLval = 1'b0;
		d5mData = '0;
		@(negedge D5M_PIXLCLK);
		d5mFval = 1'b0;
		// Vertical blanking, lets the pipeline drain
		repeat (10) @(negedge D5M_PIXLCLK);
	endtask

	// Overlay of this frame uses the spot of the one before
	task automatic runFrame(input logic captured, input logic withBright);
		makeFrame(withBright);
		if (captured)
		begin
			predictPixels();
			predictSpot();
			capturedFrames++;
		end
		driveFrame();
	endtask

	task automatic checkStatus();
		logic [31:0] word;
		word = (32'(modelSpot.found) << 31) | (32'(modelSpot.centreY) << 16) |
			32'(modelSpot.centreX);
		regCheck(camTrackPkg::regStatusAddr, word, 1'b0, "status");
	endtask

	// ========================================
	// Output stream compare
	// ========================================
	always @(negedge D5M_PIXLCLK)
	begin
		if (!rst && pixelOut.valid)
		begin
			assert (expected.size() != 0)
			else
			begin
				otherErrors++;
				$display("Output pixel at block %0d,%0d arrived when none was expected",
					pixelOut.x, pixelOut.y);
			end
			if (expected.size() != 0)
			begin
				expPixel = expected.pop_front();
				assert (pixelOut == expPixel)
				else
				begin
					valueErrors++;
					$display("Error: pixelOut expected %h got %h", expPixel, pixelOut);
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(timeoutCycles * clkPeriod);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("Value errors %0d, other errors %0d", valueErrors, otherErrors);
		$display("Done: errors found");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================
	initial
	begin
		lfsrState = 16'd96;
		valueErrors = 0;
		otherErrors = 0;
		capturedFrames = 0;
		modelSpot = '0;
		modelOverlay = 1'b0;
		rst = 1'b1;
		d5mData = '0;
		d5mFval = 1'b0;
		d5mLval = 1'b0;
		apbReq = '0;
		repeat (resetCycles) @(negedge D5M_PIXLCLK);
		rst = 1'b0;

		// Register access and error responses
		regCheck(camTrackPkg::regCtrlAddr, 32'h0, 1'b0, "control");
		regCheck(camTrackPkg::regThreshAddr, 32'h0, 1'b0, "threshold");
		regCheck(camTrackPkg::regStatusAddr, 32'h0, 1'b0, "status");
		regCheck(camTrackPkg::regFrameAddr, 32'h0, 1'b0, "frame count");
		regWrite(camTrackPkg::regCtrlAddr, 32'h2, 1'b0);
		regCheck(camTrackPkg::regCtrlAddr, 32'h2, 1'b0, "control");
		regWrite(camTrackPkg::regThreshAddr, 32'hABC, 1'b0);
		regCheck(camTrackPkg::regThreshAddr, 32'hABC, 1'b0, "threshold");
		regWrite(camTrackPkg::regStatusAddr, 32'h1234, 1'b1);
		regWrite(camTrackPkg::regFrameAddr, 32'h5, 1'b1);
		regWrite(4'h2, 32'h1, 1'b1);
		regCheck(4'h6, 32'h0, 1'b1, "unmapped");
		regCheck(camTrackPkg::regStatusAddr, 32'h0, 1'b0, "status");
		regWrite(camTrackPkg::regThreshAddr, 32'(brightLevel), 1'b0);
		regWrite(camTrackPkg::regCtrlAddr, 32'h0, 1'b0);

		// Capture off, then switched on mid frame
		runFrame(1'b0, 1'b1);
		regCheck(camTrackPkg::regFrameAddr, 32'h0, 1'b0, "frame count");
		fork
			runFrame(1'b0, 1'b1);
			begin
				repeat (4) @(negedge D5M_PIXLCLK);
				regWrite(camTrackPkg::regCtrlAddr, 32'h1, 1'b0);
			end
		join
		regCheck(camTrackPkg::regFrameAddr, 32'h0, 1'b0, "frame count");

		// Plain demosaic, one frame without a spot
		for (int i = 0; i < 4; i++)
		begin
			runFrame(1'b1, i != 1);
			checkStatus();
		end

		// Crosshair on
		regWrite(camTrackPkg::regCtrlAddr, 32'h3, 1'b0);
		modelOverlay = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			runFrame(1'b1, i != 2);
			checkStatus();
		end
		regCheck(camTrackPkg::regFrameAddr, 32'(capturedFrames), 1'b0, "frame count");

		// Capture off again, count must hold
		regWrite(camTrackPkg::regCtrlAddr, 32'h0, 1'b0);
		modelOverlay = 1'b0;
		runFrame(1'b0, 1'b1);
		regCheck(camTrackPkg::regFrameAddr, 32'(capturedFrames), 1'b0, "frame count");
		checkStatus();

		repeat (10) @(negedge D5M_PIXLCLK);
		assert (expected.size() == 0)
		else
		begin
			otherErrors++;
			$display("%0d expected output pixels never appeared", expected.size());
		end

		$display("Value errors %0d, other errors %0d", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/camTracker_assert.sv
`timescale 1ns/1ns
`default_nettype none

module camTrackerAssert
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input camTrackPkg::apbReq_t apbReq,
	input camTrackPkg::apbRsp_t apbRsp,
	input camTrackPkg::rgbPixel_t pixelOut
);

	// No wait states, so pready only in the access phase
	property readyOnlyInAccess;
		@(posedge D5M_PIXLCLK) disable iff (rst)
		apbRsp.pready |-> (apbReq.psel && apbReq.penable);
	endproperty

	property errorWithReady;
		@(posedge D5M_PIXLCLK) disable iff (rst)
		apbRsp.pslverr |-> apbRsp.pready;
	endproperty

	property validKnown;
		@(posedge D5M_PIXLCLK) disable iff (rst)
		!$isunknown(pixelOut.valid);
	endproperty

	readyCheck: assert property (readyOnlyInAccess)
		else $error("pready high outside an APB access phase");

	errorCheck: assert property (errorWithReady)
		else $error("pslverr high without pready");

	validCheck: assert property (validKnown)
		else $error("pixelOut.valid is unknown");

endmodule

bind camTracker camTrackerAssert checks0 (
	.D5M_PIXLCLK(D5M_PIXLCLK),
	.rst(rst),
	.apbReq(apbReq),
	.apbRsp(apbRsp),
	.pixelOut(pixelOut)
);

`default_nettype wire
